/* hw/mesh_pkg.sv */
package mesh_pkg;

   // port count of a mesh node
   localparam int dirs_lp = 5;

   // input buffer depth per port
   localparam int fifo_els_lp = 2;

   // coordinates and payload
   typedef logic [1:0]  x_cord_t;
   typedef logic [1:0]  y_cord_t;
   typedef logic [11:0] payload_t;

   // one bit per port
   typedef logic [dirs_lp-1:0] dir_vec_t;

   // port index, P is the local processor
   typedef enum logic [2:0] {
      P = 3'd0,
      W = 3'd1,
      E = 3'd2,
      N = 3'd3,
      S = 3'd4
   } dir_e;

   // data word of a link, 16 bits
   typedef struct packed {
      x_cord_t  dest_x;
      y_cord_t  dest_y;
      payload_t payload;
   } flit_s;

   // one direction of a ready_and link, 18 bits
   typedef struct packed {
      logic  v;
      logic  ready_and_rev;
      flit_s data;
   } link_s;

   // node placement in the two node slice
   localparam x_cord_t node0_x_lp = 2'd0;
   localparam y_cord_t node0_y_lp = 2'd0;
   localparam x_cord_t node1_x_lp = 2'd1;
   localparam y_cord_t node1_y_lp = 2'd0;

endpackage

/* hw/mesh_fifo.sv */
module mesh_fifo import mesh_pkg::*; #(
   parameter int els_p = fifo_els_lp
) (
   input  logic  clk_i,
   input  logic  reset_i,

   input  logic  v_i,
   input  flit_s data_i,
   output logic  ready_o,

   output logic  v_o,
   output flit_s data_o,
   input  logic  yumi_i
);

   typedef logic [$clog2(els_p)-1:0]   ptr_t;
   typedef logic [$clog2(els_p+1)-1:0] cnt_t;

   flit_s mem_r [els_p];
   ptr_t  rd_ptr_r;
   ptr_t  wr_ptr_r;
   cnt_t  count_r;
   logic  enq;
   logic  deq;

   // wrap by compare, so any depth works
   function automatic ptr_t ptr_next(ptr_t p);
      ptr_t nxt;
      nxt = (p == ptr_t'(els_p - 1)) ? ptr_t'(0) : ptr_t'(p + 1'b1);
      return nxt;
   endfunction

   // ready only looks at occupancy
   assign ready_o = (count_r != cnt_t'(els_p));
   assign v_o     = (count_r != cnt_t'(0));
   assign data_o  = mem_r[rd_ptr_r];

   assign enq = v_i & ready_o;
   assign deq = yumi_i;

   always_ff @(posedge clk_i) begin
      if (!reset_i) begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
      end else begin
         if (enq) begin
            wr_ptr_r <= ptr_next(wr_ptr_r);
         end
         if (deq) begin
            rd_ptr_r <= ptr_next(rd_ptr_r);
         end
         case ({enq, deq})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

   // storage array
   always_ff @(posedge clk_i) begin
      if (enq) begin
         mem_r[wr_ptr_r] <= data_i;
      end
   end

endmodule

/* hw/mesh_rr_arbiter.sv */
module mesh_rr_arbiter import mesh_pkg::*; (
   input  logic     clk_i,
   input  logic     reset_i,

   input  dir_vec_t req_i,
   output dir_vec_t grant_o,
   input  logic     grant_used_i
);

   dir_e ptr_r;
   dir_e hold_r;
   logic hold_v_r;
   dir_e start;
   dir_e winner;
   logic found;

   // a stalled winner keeps its grant until the grant is taken
   assign start = hold_v_r ? hold_r : ptr_r;

   // search starting at the pointer, first request wins
   always_comb begin
      int idx;
      grant_o = '0;
      winner  = P;
      found   = 1'b0;
      for (int i = 0; i < dirs_lp; i++) begin
         idx = (int'(start) + i) % dirs_lp;
         if (!found && req_i[idx]) begin
            found        = 1'b1;
            grant_o[idx] = 1'b1;
            winner       = dir_e'(idx);
         end
      end
   end

   // move past the winner once its grant has been taken
   always_ff @(posedge clk_i) begin
      if (!reset_i) begin
         ptr_r    <= P;
         hold_r   <= P;
         hold_v_r <= 1'b0;
      end else begin
         hold_r   <= winner;
         hold_v_r <= found && !grant_used_i;
         if (grant_used_i && found) begin
            if (winner == S) begin
               ptr_r <= P;
            end else begin
               ptr_r <= dir_e'(winner + 3'd1);
            end
         end
      end
   end

endmodule

/* hw/mesh_router.sv */
module mesh_router import mesh_pkg::*; #(
   parameter x_cord_t my_x_p = '0,
   parameter y_cord_t my_y_p = '0
) (
   input  logic     clk_i,
   input  logic     reset_i,

   // fifo heads
   input  dir_vec_t v_i,
   input  flit_s    data_i [dirs_lp],
   output dir_vec_t yumi_o,

   // output links
   output dir_vec_t v_o,
   output flit_s    data_o [dirs_lp],
   input  dir_vec_t ready_i
);

   dir_e     route [dirs_lp];
   dir_vec_t req   [dirs_lp];
   dir_vec_t grant [dirs_lp];
   dir_vec_t used;

   // dimension ordered, x first then y
   always_comb begin
      for (int i = 0; i < dirs_lp; i++) begin
         if (data_i[i].dest_x > my_x_p) begin
            route[i] = E;
         end else if (data_i[i].dest_x < my_x_p) begin
            route[i] = W;
         end else if (data_i[i].dest_y > my_y_p) begin
            route[i] = S;
         end else if (data_i[i].dest_y < my_y_p) begin
            route[i] = N;
         end else begin
            route[i] = P;
         end
      end
   end

   // request matrix, indexed by output then input
   always_comb begin
      for (int o = 0; o < dirs_lp; o++) begin
         for (int i = 0; i < dirs_lp; i++) begin
            req[o][i] = v_i[i] && (route[i] == dir_e'(o));
         end
      end
   end

   for (genvar o = 0; o < dirs_lp; o++) begin : g_out
      mesh_rr_arbiter u_arb (
         .clk_i        (clk_i),
         .reset_i      (reset_i),
         .req_i        (req[o]),
         .grant_o      (grant[o]),
         .grant_used_i (used[o])
      );

      assign v_o[o]  = |req[o];
      assign used[o] = v_o[o] & ready_i[o];
   end

   // crossbar, grants are one-hot
   always_comb begin
      for (int o = 0; o < dirs_lp; o++) begin
         data_o[o] = '0;
         for (int i = 0; i < dirs_lp; i++) begin
            if (grant[o][i]) begin
               data_o[o] = data_i[i];
            end
         end
      end
   end

   // each input targets one output, so at most one term is set
   always_comb begin
      yumi_o = '0;
      for (int i = 0; i < dirs_lp; i++) begin
         for (int o = 0; o < dirs_lp; o++) begin
            if (grant[o][i] && ready_i[o]) begin
               yumi_o[i] = 1'b1;
            end
         end
      end
   end

endmodule

/* hw/mesh_router_buffered.sv */
module mesh_router_buffered import mesh_pkg::*; #(
   parameter x_cord_t my_x_p = '0,
   parameter y_cord_t my_y_p = '0
) (
   input  logic  clk_i,
   input  logic  reset_i,

   input  link_s link_i [dirs_lp],
   output link_s link_o [dirs_lp]
);

   // fifo side
   dir_vec_t fifo_ready;
   dir_vec_t fifo_v;
   flit_s    fifo_data [dirs_lp];
   dir_vec_t fifo_yumi;

   // router output side
   dir_vec_t router_v;
   flit_s    router_data [dirs_lp];
   dir_vec_t router_ready;

   for (genvar i = 0; i < dirs_lp; i++) begin : g_port
      mesh_fifo #(
         .els_p (fifo_els_lp)
      ) u_fifo (
         .clk_i   (clk_i),
         .reset_i (reset_i),
         .v_i     (link_i[i].v),
         .data_i  (link_i[i].data),
         .ready_o (fifo_ready[i]),
         .v_o     (fifo_v[i]),
         .data_o  (fifo_data[i]),
         .yumi_i  (fifo_yumi[i])
      );

      // downstream ready comes back on the incoming link
      assign router_ready[i] = link_i[i].ready_and_rev;

      assign link_o[i].v             = router_v[i];
      assign link_o[i].ready_and_rev = fifo_ready[i];
      assign link_o[i].data          = router_data[i];
   end

   mesh_router #(
      .my_x_p (my_x_p),
      .my_y_p (my_y_p)
   ) u_router (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (fifo_v),
      .data_i  (fifo_data),
      .yumi_o  (fifo_yumi),
      .v_o     (router_v),
      .data_o  (router_data),
      .ready_i (router_ready)
   );

endmodule

/* hw/mesh_top.sv */
module mesh_top import mesh_pkg::*; (
   input  logic  clk_i,
   input  logic  reset_i,

   input  link_s node0_link_i [dirs_lp],
   output link_s node0_link_o [dirs_lp],

   input  link_s node1_link_i [dirs_lp],
   output link_s node1_link_o [dirs_lp]
);

   link_s node0_li [dirs_lp];
   link_s node0_lo [dirs_lp];
   link_s node1_li [dirs_lp];
   link_s node1_lo [dirs_lp];

   // node0 east faces node1 west, external slots there are ignored
   always_comb begin
      node0_li    = node0_link_i;
      node0_li[E] = node1_lo[W];
      node1_li    = node1_link_i;
      node1_li[W] = node0_lo[E];
   end

   // internal slots show up as idle on the external arrays
   always_comb begin
      node0_link_o    = node0_lo;
      node0_link_o[E] = '0;
      node1_link_o    = node1_lo;
      node1_link_o[W] = '0;
   end

   mesh_router_buffered #(
      .my_x_p (node0_x_lp),
      .my_y_p (node0_y_lp)
   ) node0 (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .link_i  (node0_li),
      .link_o  (node0_lo)
   );

   mesh_router_buffered #(
      .my_x_p (node1_x_lp),
      .my_y_p (node1_y_lp)
   ) node1 (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .link_i  (node1_li),
      .link_o  (node1_lo)
   );

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen #(
   parameter int period_p       = 40,
   parameter int reset_cycles_p = 5
) (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever #(period_p / 2) clk_o = ~clk_o;
   end

   // active low, released on a rising edge
   initial begin
      reset_o = 1'b0;
      repeat (reset_cycles_p) @(posedge clk_o);
      reset_o <= 1'b1;
   end

endmodule

/* tb/mesh_props.sv */
module mesh_props import mesh_pkg::*; (
   input logic  clk_i,
   input logic  reset_i,
   // external arrays of mesh_top
   input link_s n0_in_i  [dirs_lp],
   input link_s n0_out_i [dirs_lp],
   input link_s n1_in_i  [dirs_lp],
   input link_s n1_out_i [dirs_lp]
);

   // node0 has no external E, node1 no external W
   localparam dir_vec_t n0_ext        = 5'b11011;
   localparam dir_vec_t n1_ext        = 5'b11101;
   localparam int       max_in_flight = 10 * fifo_els_lp + 2;

   dir_vec_t n0_src_v, n0_fifo_rdy, n0_out_v, n0_sink_rdy;
   dir_vec_t n1_src_v, n1_fifo_rdy, n1_out_v, n1_sink_rdy;
   dir_vec_t n0_route_ok, n1_route_ok;
   logic     ext_idle, probe_near, probe_far;
   logic     was_in_reset_r = 1'b0;
   int       in_xfers, out_xfers;
   int       in_flight_r, idle_cycles_r;
   int       fail_count = 0;

   always_comb begin
      for (int i = 0; i < dirs_lp; i++) begin
         n0_src_v[i]    = n0_in_i[i].v;
         n0_fifo_rdy[i] = n0_out_i[i].ready_and_rev;
         n0_out_v[i]    = n0_out_i[i].v;
         n0_sink_rdy[i] = n0_in_i[i].ready_and_rev;
         n1_src_v[i]    = n1_in_i[i].v;
         n1_fifo_rdy[i] = n1_out_i[i].ready_and_rev;
         n1_out_v[i]    = n1_out_i[i].v;
         n1_sink_rdy[i] = n1_in_i[i].ready_and_rev;
      end
   end

   // legal destinations per external output under XY order
   always_comb begin
      n0_route_ok    = '0;
      n1_route_ok    = '0;
      n0_route_ok[P] = n0_out_i[P].data.dest_x == 2'd0 && n0_out_i[P].data.dest_y == 2'd0;
      n0_route_ok[S] = n0_out_i[S].data.dest_x == 2'd0 && n0_out_i[S].data.dest_y != 2'd0;
      n1_route_ok[P] = n1_out_i[P].data.dest_x == 2'd1 && n1_out_i[P].data.dest_y == 2'd0;
      n1_route_ok[E] = n1_out_i[E].data.dest_x >= 2'd2;
      n1_route_ok[S] = n1_out_i[S].data.dest_x == 2'd1 && n1_out_i[S].data.dest_y != 2'd0;
   end

   assign in_xfers  = $countones(n0_src_v & n0_fifo_rdy & n0_ext) +
                      $countones(n1_src_v & n1_fifo_rdy & n1_ext);
   assign out_xfers = $countones(n0_out_v & n0_sink_rdy & n0_ext) +
                      $countones(n1_out_v & n1_sink_rdy & n1_ext);
   assign ext_idle  = ((n0_src_v & n0_ext) == '0) && ((n1_src_v & n1_ext) == '0) &&
                      ((n0_sink_rdy & n0_ext) == n0_ext) && ((n1_sink_rdy & n1_ext) == n1_ext);

   // single flit into node0 P of an empty network
   assign probe_near = in_flight_r == 0 && in_xfers == 1 && n0_src_v[P] && n0_fifo_rdy[P] &&
                       n0_in_i[P].data.dest_x == 2'd0 && n0_in_i[P].data.dest_y == 2'd1;
   assign probe_far  = in_flight_r == 0 && in_xfers == 1 && n0_src_v[P] && n0_fifo_rdy[P] &&
                       n0_in_i[P].data.dest_x == 2'd1 && n0_in_i[P].data.dest_y == 2'd1;

   always_ff @(posedge clk_i) begin
      was_in_reset_r <= !reset_i;
      if (!reset_i) begin
         in_flight_r   <= 0;
         idle_cycles_r <= 0;
      end else begin
         in_flight_r <= in_flight_r + in_xfers - out_xfers;
         if (!ext_idle) begin
            idle_cycles_r <= 0;
         end else if (idle_cycles_r < 1000) begin
            idle_cycles_r <= idle_cycles_r + 1;
         end
      end
   end

   a_reset: assert property (@(posedge clk_i) was_in_reset_r |->
      (n0_out_v & n0_ext) == '0 && (n1_out_v & n1_ext) == '0 &&
      (n0_fifo_rdy & n0_ext) == n0_ext && (n1_fifo_rdy & n1_ext) == n1_ext)
      else begin
         fail_count++;
         $error("outputs not idle or inputs not ready around reset");
      end

   a_route: assert property (@(posedge clk_i) disable iff (!reset_i)
      (n0_out_v & n0_ext & ~n0_route_ok) == '0 && (n1_out_v & n1_ext & ~n1_route_ok) == '0)
      else begin
         fail_count++;
         $error("flit left on a port that XY routing forbids");
      end

   a_count: assert property (@(posedge clk_i) disable iff (!reset_i)
      in_flight_r >= 0 && in_flight_r <= max_in_flight)
      else begin
         fail_count++;
         $error("flits in flight out of range: %0d", in_flight_r);
      end

   a_drained: assert property (@(posedge clk_i) disable iff (!reset_i)
      idle_cycles_r >= 20 |-> in_flight_r == 0)
      else begin
         fail_count++;
         $error("network idle but %0d flits missing", in_flight_r);
      end

   a_near: assert property (@(posedge clk_i) disable iff (!reset_i)
      probe_near |=> n0_out_i[S].v && n0_out_i[S].data == $past(n0_in_i[P].data))
      else begin
         fail_count++;
         $error("one hop probe not on node0 S after 1 cycle");
      end

   a_far: assert property (@(posedge clk_i) disable iff (!reset_i)
      probe_far ##1 in_xfers == 0 |=>
         n1_out_i[S].v && n1_out_i[S].data == $past(n0_in_i[P].data, 2))
      else begin
         fail_count++;
         $error("two hop probe not on node1 S after 2 cycles");
      end

   // a stalled output keeps its flit until the sink takes it
   for (genvar i = 0; i < dirs_lp; i++) begin : g_port
      a_n0_hold: assert property (@(posedge clk_i) disable iff (!reset_i)
         n0_out_i[i].v && !n0_in_i[i].ready_and_rev |=>
            n0_out_i[i].v && $stable(n0_out_i[i].data))
         else begin
            fail_count++;
            $error("node0 stalled output changed");
         end
      a_n1_hold: assert property (@(posedge clk_i) disable iff (!reset_i)
         n1_out_i[i].v && !n1_in_i[i].ready_and_rev |=>
            n1_out_i[i].v && $stable(n1_out_i[i].data))
         else begin
            fail_count++;
            $error("node1 stalled output changed");
         end
   end

endmodule

/* tb/mesh_tb.sv */
module mesh_tb import mesh_pkg::*; ();

   localparam int n_ext           = 8;
   localparam int flits_per_src   = 300;
   localparam int total_flits     = n_ext * flits_per_src + 2;
   localparam int watchdog_cycles = total_flits * 30 + 2000;

   logic  clk;
   logic  reset_n;
   link_s node0_in  [dirs_lp];
   link_s node0_out [dirs_lp];
   link_s node1_in  [dirs_lp];
   link_s node1_out [dirs_lp];

   // external ports, node0 has no E and node1 no W
   int    ext_node [n_ext] = '{0, 0, 0, 0, 1, 1, 1, 1};
   dir_e  ext_dir  [n_ext] = '{P, W, N, S, P, E, N, S};

   int    src_sent [n_ext];
   int    sent;
   int    received;
   int    errors;
   logic  src_on;
   logic  stall_phase;
   int    phase_left;

   tb_clock_gen #(
      .period_p       (40),
      .reset_cycles_p (5)
   ) i_clock_gen (
      .clk_o   (clk),
      .reset_o (reset_n)
   );

   mesh_top i_mesh_top (
      .clk_i        (clk),
      .reset_i      (reset_n),
      .node0_link_i (node0_in),
      .node0_link_o (node0_out),
      .node1_link_i (node1_in),
      .node1_link_o (node1_out)
   );

   bind mesh_top mesh_props i_mesh_props (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .n0_in_i  (node0_link_i),
      .n0_out_i (node0_link_o),
      .n1_in_i  (node1_link_i),
      .n1_out_i (node1_link_o)
   );

   function automatic link_s out_link(int k);
      return (ext_node[k] == 0) ? node0_out[ext_dir[k]] : node1_out[ext_dir[k]];
   endfunction

   function automatic link_s in_link(int k);
      return (ext_node[k] == 0) ? node0_in[ext_dir[k]] : node1_in[ext_dir[k]];
   endfunction

   task automatic drive_src(int k, logic v, flit_s f);
      if (ext_node[k] == 0) begin
         node0_in[ext_dir[k]].v    <= v;
         node0_in[ext_dir[k]].data <= f;
      end else begin
         node1_in[ext_dir[k]].v    <= v;
         node1_in[ext_dir[k]].data <= f;
      end
   endtask

   task automatic drive_sink(int k, logic rdy);
      if (ext_node[k] == 0) begin
         node0_in[ext_dir[k]].ready_and_rev <= rdy;
      end else begin
         node1_in[ext_dir[k]].ready_and_rev <= rdy;
      end
   endtask

   function automatic flit_s random_flit(int k);
      x_cord_t dx [6] = '{2'd0, 2'd1, 2'd2, 2'd0, 2'd1, 2'd0};
      y_cord_t dy [6] = '{2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd3};
      flit_s   f;
      int      pick;
      pick      = $urandom_range(5);
      f.dest_x  = dx[pick];
      f.dest_y  = dy[pick];
      f.payload = payload_t'(k * 512 + src_sent[k]);
      return f;
   endfunction

   // one rising edge worth of source and sink activity
   task automatic step_cycle();
      link_s drv;
      link_s mon;
      for (int k = 0; k < n_ext; k++) begin
         drv = in_link(k);
         mon = out_link(k);
         if (mon.v && drv.ready_and_rev) begin
            received++;
         end
         if (drv.v && mon.ready_and_rev) begin
            sent++;
            src_sent[k]++;
         end
         if (drv.v && !mon.ready_and_rev) begin
            drive_src(k, 1'b1, drv.data);
         end else if (src_on && src_sent[k] < flits_per_src && $urandom_range(3) != 0) begin
            drive_src(k, 1'b1, random_flit(k));
         end else begin
            drive_src(k, 1'b0, drv.data);
         end
         drive_sink(k, !stall_phase || $urandom_range(3) == 0);
      end
      if (phase_left == 0) begin
         stall_phase = src_on && !stall_phase;
         phase_left  = 20 + $urandom_range(60);
      end else begin
         phase_left--;
      end
   endtask

   task automatic send_probe(x_cord_t dx, y_cord_t dy, int node, payload_t pl);
      flit_s f;
      link_s mon;
      logic  seen;
      f.dest_x = dx;
      f.dest_y = dy;
      f.payload = pl;
      seen = 1'b0;
      node0_in[P].v    <= 1'b1;
      node0_in[P].data <= f;
      do begin
         @(posedge clk);
      end while (!node0_out[P].ready_and_rev);
      sent++;
      node0_in[P].v <= 1'b0;
      for (int c = 0; c < 10 && !seen; c++) begin
         @(posedge clk);
         mon = (node == 0) ? node0_out[S] : node1_out[S];
         if (mon.v) begin
            seen = 1'b1;
            received++;
            if (mon.data !== f) begin
               errors++;
               $display("[ERROR] %0t node%0d S data: got %h expected %h",
                        $time, node, mon.data, f);
            end
         end
      end
      if (!seen) begin
         errors++;
         $display("probe for (%0d,%0d) never left node%0d S", dx, dy, node);
      end
   endtask

   task automatic print_counts();
      $display("flits sent %0d received %0d, testbench errors %0d, assertion failures %0d",
               sent, received, errors, i_mesh_top.i_mesh_props.fail_count);
   endtask

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, network did not drain", watchdog_cycles);
      print_counts();
      $display("Test failures found");
      $finish;
   end

   initial begin
      void'($urandom(32'h72f6));
      sent        = 0;
      received    = 0;
      errors      = 0;
      src_on      = 1'b0;
      stall_phase = 1'b0;
      phase_left  = 40;
      for (int k = 0; k < n_ext; k++) begin
         src_sent[k] = 0;
      end
      for (int d = 0; d < dirs_lp; d++) begin
         node0_in[d]               = '0;
         node0_in[d].ready_and_rev = 1'b1;
         node1_in[d]               = '0;
         node1_in[d].ready_and_rev = 1'b1;
      end
      do begin
         @(posedge clk);
      end while (!reset_n);
      repeat (3) @(posedge clk);

      // latency probes into an empty network
      send_probe(2'd0, 2'd1, 0, 12'h0a1);
      repeat (4) @(posedge clk);
      send_probe(2'd1, 2'd1, 1, 12'h0b2);
      repeat (4) @(posedge clk);

      src_on = 1'b1;
      while (sent < total_flits) begin
         @(posedge clk);
         step_cycle();
      end
      // drain with every sink ready
      src_on      = 1'b0;
      stall_phase = 1'b0;
      while (received < sent) begin
         @(posedge clk);
         step_cycle();
      end
      repeat (25) begin
         @(posedge clk);
         step_cycle();
      end
      if (received != sent) begin
         errors++;
         $display("[ERROR] %0t received: got %0d expected %0d", $time, received, sent);
      end
      print_counts();
      if (errors == 0 && i_mesh_top.i_mesh_props.fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* tb.f */
hw/mesh_pkg.sv
hw/mesh_fifo.sv
hw/mesh_rr_arbiter.sv
hw/mesh_router.sv
hw/mesh_router_buffered.sv
hw/mesh_top.sv
tb/tb_clock_gen.sv
tb/mesh_props.sv
tb/mesh_tb.sv
